/* common/rffe_pkg.sv */
// rffe master package: widths, bus constants, state and opcode enums, header/frame/write structs
package rffe_pkg;

   ////////////////////////////////////////////////////////////
   // widths and bus constants
   ////////////////////////////////////////////////////////////
   localparam int unsigned C_BYTE_W  = 8;
   localparam int unsigned C_SA_W    = 4;    // slave address bits
   localparam int unsigned C_BUF_AW  = 5;    // user buffer address width
   localparam logic [1:0]  C_SSC_PAT = 2'b10; // sequence start, high then low
   localparam int unsigned C_MIN_DIV = 2;

   ////////////////////////////////////////////////////////////
   // enums
   ////////////////////////////////////////////////////////////
   typedef enum logic [2:0] {
      st_idle,
      st_ssc,
      st_sa,
      st_cmd,
      st_addr,
      st_park,   // bus turnaround before read data
      st_data,
      st_fin     // closing bus park
   } rffe_state_e;

   typedef enum logic [2:0] {
      op_reg_wr,
      op_reg_rd,
      op_ext_wr,
      op_ext_rd,
      op_invalid
   } rffe_op_e;

   ////////////////////////////////////////////////////////////
   // structs
   ////////////////////////////////////////////////////////////
   // header as loaded by the user
   typedef struct packed {
      logic [C_SA_W-1:0]   sa;
      logic [C_BYTE_W-1:0] cmd;
      logic [C_BYTE_W-1:0] addr;
   } rffe_hdr_t;

   // decoded frame, held for the whole transfer
   typedef struct packed {
      rffe_op_e            op;
      logic [C_SA_W-1:0]   sa;
      logic [C_BYTE_W-1:0] cmd;      // command field as sent on the bus
      logic [C_BYTE_W-1:0] addr;
      logic                has_addr; // extended frames carry an address byte
      logic [3:0]          last_idx; // data bytes minus one
   } rffe_frame_t;

   // engine write into the data region
   typedef struct packed {
      logic                wr;
      logic [3:0]          idx;
      logic [C_BYTE_W-1:0] data;
   } rffe_wr_t;

endpackage

/* design/rffe_clk_div.sv */
// bit-period divider: clamped divide value, down-counter, tick enable and sclk phase
module rffe_clk_div
   import rffe_pkg::*;
#(
   parameter int unsigned DIV_W = 8
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_div_set,
   input  logic [DIV_W-1:0] i_div,
   output logic             o_tick,
   output logic             o_phase
);

   logic [DIV_W-1:0] div_r;
   logic [DIV_W-1:0] cnt;
   logic [DIV_W-1:0] div_clamp;
   logic [DIV_W-1:0] cnt_nxt;

   // anything below the minimum runs at the minimum
   assign div_clamp = (i_div < DIV_W'(C_MIN_DIV)) ? DIV_W'(C_MIN_DIV) : i_div;

   assign o_tick  = (cnt == '0);
   assign cnt_nxt = o_tick ? div_r - 1'b1 : cnt - 1'b1;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         div_r   <= DIV_W'(C_MIN_DIV);
         cnt     <= DIV_W'(C_MIN_DIV - 1);
         o_phase <= 1'b1;
      end else if (i_div_set) begin
         div_r   <= div_clamp;
         cnt     <= div_clamp - 1'b1;
         o_phase <= 1'b1;
      end else begin
         cnt     <= cnt_nxt;
         o_phase <= (cnt_nxt >= (div_r >> 1)); // high in the first half
      end
   end

endmodule

/* design/rffe_frame_buf.sv */
// frame buffer: header registers, data byte memory, user port and engine ports
module rffe_frame_buf
   import rffe_pkg::*;
#(
   parameter int unsigned DATA_DEPTH = 16
) (
   input  logic                         clk,
   input  logic                         i_rst_n,
   input  logic                         i_busy,
   input  logic                         i_buf_wr,
   input  logic [C_BUF_AW-1:0]          i_buf_addr,
   input  logic [C_BYTE_W-1:0]          i_buf_wdata,
   input  logic [$clog2(DATA_DEPTH)-1:0] i_rd_idx,
   input  rffe_wr_t                     i_cap,
   output logic [C_BYTE_W-1:0]          o_buf_rdata,
   output rffe_hdr_t                    o_hdr,
   output logic [C_BYTE_W-1:0]          o_wr_byte
);

   localparam int unsigned IDX_W = $clog2(DATA_DEPTH);
   // user map: 0 sa, 1 cmd, 2 addr, 3.. data
   localparam logic [C_BUF_AW-1:0] A_SA   = C_BUF_AW'(0);
   localparam logic [C_BUF_AW-1:0] A_CMD  = C_BUF_AW'(1);
   localparam logic [C_BUF_AW-1:0] A_ADDR = C_BUF_AW'(2);
   localparam logic [C_BUF_AW-1:0] A_DATA = C_BUF_AW'(3);

   logic [C_BYTE_W-1:0] mem [DATA_DEPTH];
   logic [IDX_W-1:0]    data_idx;
   logic                in_data;

   assign data_idx  = IDX_W'(i_buf_addr - A_DATA);
   assign in_data   = (i_buf_addr >= A_DATA) && (i_buf_addr < A_DATA + C_BUF_AW'(DATA_DEPTH));
   assign o_wr_byte = mem[i_rd_idx]; // engine side, no latency

   // header, user writes only between frames
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_hdr <= '0;
      end else if (i_buf_wr && !i_busy) begin
         case (i_buf_addr)
            A_SA:    o_hdr.sa   <= i_buf_wdata[C_SA_W-1:0];
            A_CMD:   o_hdr.cmd  <= i_buf_wdata;
            A_ADDR:  o_hdr.addr <= i_buf_wdata;
            default: ;
         endcase
      end
   end

   // data bytes, engine writes read results
   always_ff @(posedge clk) begin
      if (i_cap.wr)
         mem[i_cap.idx] <= i_cap.data;
      else if (i_buf_wr && !i_busy && in_data)
         mem[data_idx] <= i_buf_wdata;
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         o_buf_rdata <= '0;
      else if (i_buf_addr == A_SA)
         o_buf_rdata <= {{(C_BYTE_W-C_SA_W){1'b0}}, o_hdr.sa};
      else if (i_buf_addr == A_CMD)
         o_buf_rdata <= o_hdr.cmd;
      else if (i_buf_addr == A_ADDR)
         o_buf_rdata <= o_hdr.addr;
      else
         o_buf_rdata <= in_data ? mem[data_idx] : '0;
   end

endmodule

/* rffe_engine/rffe_cmd_decode.sv */
// command decoder: classifies the command byte, builds the frame description, latches at start
module rffe_cmd_decode
   import rffe_pkg::*;
(
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic        i_start,
   input  logic        i_busy,
   input  rffe_hdr_t   i_hdr,
   output rffe_frame_t o_frame,
   output logic        o_frame_vld
);

   rffe_frame_t nxt;
   logic        accept;

   assign accept = i_start && !i_busy;

   ////////////////////////////////////////////////////////////
   // decode stage
   ////////////////////////////////////////////////////////////
   always_comb begin
      nxt          = '0;
      nxt.sa       = i_hdr.sa;
      nxt.addr     = i_hdr.addr;
      nxt.cmd      = i_hdr.cmd;
      casez (i_hdr.cmd)
         8'b010?_????: begin // register write
            nxt.op  = op_reg_wr;
            nxt.cmd = {i_hdr.cmd[7:5], i_hdr.addr[4:0]};
         end
         8'b011?_????: begin // register read
            nxt.op  = op_reg_rd;
            nxt.cmd = {i_hdr.cmd[7:5], i_hdr.addr[4:0]};
         end
         8'b0000_????: begin // extended write, low nibble is byte count - 1
            nxt.op       = op_ext_wr;
            nxt.has_addr = 1'b1;
            nxt.last_idx = i_hdr.cmd[3:0];
         end
         8'b0010_????: begin
            nxt.op       = op_ext_rd;
            nxt.has_addr = 1'b1;
            nxt.last_idx = i_hdr.cmd[3:0];
         end
         default: nxt.op = op_invalid; // long forms, reg0 write and the rest
      endcase
   end

   // held stable while the frame runs
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_frame     <= '0;
         o_frame_vld <= 1'b0;
      end else begin
         o_frame_vld <= accept;
         if (accept)
            o_frame <= nxt;
      end
   end

endmodule

/* rffe_engine/rffe_frame_seq.sv */
// frame sequencer: state machine, bit shifter, odd parity, pad drive and read sample strobes
module rffe_frame_seq
   import rffe_pkg::*;
#(
   parameter int unsigned DATA_DEPTH = 16
) (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic                          i_tick,
   input  rffe_frame_t                   i_frame,
   input  logic                          i_frame_vld,
   input  logic [C_BYTE_W-1:0]           i_wr_byte,
   input  logic                          i_sdi,
   output logic                          o_busy,
   output logic                          o_done,
   output logic [$clog2(DATA_DEPTH)-1:0] o_rd_idx,
   output logic                          o_sclk_en,
   output logic                          o_sdo,
   output logic                          o_sdo_en,
   output logic                          o_smp,
   output logic                          o_smp_bit,
   output logic                          o_byte_end
);

   localparam int unsigned IDX_W = $clog2(DATA_DEPTH);
   localparam logic [3:0]  BYTE_LAST = 4'(C_BYTE_W); // 8 bits then parity at 0

   rffe_state_e         st;
   logic                run;       // frame accepted, up to done
   logic [3:0]          cnt;       // bits left in the field
   logic [C_BYTE_W-1:0] sreg;
   logic                par;       // running xor of the sent bits
   logic [IDX_W-1:0]    byte_idx;
   logic                is_rd;
   logic                bit_out;

   assign is_rd   = (i_frame.op == op_reg_rd) || (i_frame.op == op_ext_rd);
   assign bit_out = sreg[C_BYTE_W-1]; // msb first

   ////////////////////////////////////////////////////////////
   // state machine, steps only on ticks
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         st       <= st_idle;
         run      <= 1'b0;
         o_done   <= 1'b0;
         cnt      <= '0;
         sreg     <= '0;
         par      <= 1'b0;
         byte_idx <= '0;
      end else begin
         o_done <= 1'b0;
         if (i_frame_vld) begin
            if (i_frame.op == op_invalid)
               o_done <= 1'b1; // nothing goes on the bus
            else
               run <= 1'b1;
         end
         if (i_tick) begin
            case (st)
               st_idle: begin
                  if (run) begin
                     st       <= st_ssc;
                     cnt      <= 4'd1;
                     par      <= 1'b0;
                     byte_idx <= '0;
                  end
               end
               st_ssc: begin
                  cnt <= cnt - 1'b1;
                  if (cnt == '0) begin
                     st   <= st_sa;
                     cnt  <= 4'(C_SA_W - 1);
                     sreg <= {i_frame.sa, {(C_BYTE_W-C_SA_W){1'b0}}};
                  end
               end
               st_sa: begin
                  par  <= par ^ bit_out;
                  sreg <= sreg << 1;
                  cnt  <= cnt - 1'b1;
                  if (cnt == '0) begin
                     st   <= st_cmd;
                     cnt  <= BYTE_LAST;
                     sreg <= i_frame.cmd; // parity keeps running over sa and cmd
                  end
               end
               st_cmd, st_addr: begin
                  if (cnt != '0) begin
                     par  <= par ^ bit_out;
                     sreg <= sreg << 1;
                     cnt  <= cnt - 1'b1;
                  end else begin
                     par <= 1'b0;
                     cnt <= BYTE_LAST;
                     if (st == st_cmd && i_frame.has_addr) begin
                        st   <= st_addr;
                        sreg <= i_frame.addr;
                     end else if (is_rd) begin
                        st <= st_park;
                     end else begin
                        st   <= st_data;
                        sreg <= i_wr_byte; // byte 0
                     end
                  end
               end
               st_park: begin
                  st   <= st_data;
                  sreg <= '0;
               end
               st_data: begin
                  if (cnt != '0) begin
                     par  <= par ^ bit_out;
                     sreg <= sreg << 1;
                     cnt  <= cnt - 1'b1;
                  end else begin
                     par <= 1'b0;
                     cnt <= BYTE_LAST;
                     if (byte_idx == i_frame.last_idx) begin
                        st <= st_fin;
                     end else begin
                        byte_idx <= byte_idx + 1'b1;
                        sreg     <= i_wr_byte;
                     end
                  end
               end
               st_fin: begin
                  st     <= st_idle;
                  run    <= 1'b0;
                  o_done <= 1'b1; // busy drops on this edge
               end
               default: st <= st_idle;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // pad drive, changes only with the state registers
   ////////////////////////////////////////////////////////////
   always_comb begin
      o_sdo     = 1'b0;
      o_sdo_en  = 1'b0;
      o_sclk_en = 1'b1;
      case (st)
         st_idle: o_sclk_en = 1'b0;
         st_ssc: begin
            o_sclk_en = 1'b0;
            o_sdo_en  = 1'b1;
            o_sdo     = C_SSC_PAT[cnt[0]];
         end
         st_sa: begin
            o_sdo_en = 1'b1;
            o_sdo    = bit_out;
         end
         st_cmd, st_addr: begin
            o_sdo_en = 1'b1;
            o_sdo    = (cnt == '0) ? ~par : bit_out;
         end
         st_data: begin
            o_sdo_en = !is_rd; // slave owns the line on reads
            o_sdo    = is_rd ? 1'b0 : ((cnt == '0) ? ~par : bit_out);
         end
         default: ; // park and fin, line released
      endcase
   end

   assign o_busy     = run | i_frame_vld;
   assign o_rd_idx   = (st == st_data) ? byte_idx + 1'b1 : '0; // next byte to load
   assign o_smp      = i_tick && (st == st_data) && is_rd && (cnt != '0);
   assign o_byte_end = i_tick && (st == st_data) && is_rd && (cnt == '0);
   assign o_smp_bit  = i_sdi;

endmodule

/* rffe_engine/rffe_rd_capture.sv */
// read capture: shifts sampled sdi bits into bytes and writes them back to the data region
module rffe_rd_capture
   import rffe_pkg::*;
(
   input  logic     clk,
   input  logic     i_rst_n,
   input  logic     i_frame_vld,
   input  logic     i_smp,
   input  logic     i_smp_bit,
   input  logic     i_byte_end,
   output rffe_wr_t o_cap
);

   logic [C_BYTE_W-1:0] shreg;
   logic [3:0]          idx;

   // msb arrives first
   always_ff @(posedge clk) begin
      if (i_smp)
         shreg <= {shreg[C_BYTE_W-2:0], i_smp_bit};
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         idx   <= '0;
         o_cap <= '0;
      end else begin
         o_cap.wr <= 1'b0;
         if (i_frame_vld)
            idx <= '0;
         if (i_byte_end) begin // slave parity bit is dropped
            o_cap.wr   <= 1'b1;
            o_cap.idx  <= idx;
            o_cap.data <= shreg;
            idx        <= idx + 1'b1;
         end
      end
   end

endmodule

/* design/rffe_master.sv */
// rffe bus master top level: clock divider, frame buffer, decoder, sequencer, read capture
module rffe_master
   import rffe_pkg::*;
#(
   parameter int unsigned DIV_W      = 8,
   parameter int unsigned DATA_DEPTH = 16
) (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_div_set,
   input  logic [DIV_W-1:0]    i_div,
   input  logic                i_start,
   output logic                o_busy,
   output logic                o_done,
   input  logic                i_buf_wr,
   input  logic [C_BUF_AW-1:0] i_buf_addr,
   input  logic [C_BYTE_W-1:0] i_buf_wdata,
   output logic [C_BYTE_W-1:0] o_buf_rdata,
   output logic                o_sclk,
   input  logic                i_sdi,
   output logic                o_sdo,
   output logic                o_sdo_en
);

   localparam int unsigned IDX_W = $clog2(DATA_DEPTH);

   logic                tick;
   logic                phase;
   logic                sclk_en;
   rffe_hdr_t           hdr;
   rffe_frame_t         frame;
   logic                frame_vld;
   logic [IDX_W-1:0]    rd_idx;
   logic [C_BYTE_W-1:0] wr_byte;
   logic                smp;
   logic                smp_bit;
   logic                byte_end;
   rffe_wr_t            cap;

   rffe_clk_div #(.DIV_W(DIV_W)) u_clk_div (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_div_set (i_div_set),
      .i_div     (i_div),
      .o_tick    (tick),
      .o_phase   (phase)
   );

   rffe_frame_buf #(.DATA_DEPTH(DATA_DEPTH)) u_frame_buf (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_busy      (o_busy),
      .i_buf_wr    (i_buf_wr),
      .i_buf_addr  (i_buf_addr),
      .i_buf_wdata (i_buf_wdata),
      .i_rd_idx    (rd_idx),
      .i_cap       (cap),
      .o_buf_rdata (o_buf_rdata),
      .o_hdr       (hdr),
      .o_wr_byte   (wr_byte)
   );

   rffe_cmd_decode u_cmd_decode (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_start     (i_start),
      .i_busy      (o_busy),
      .i_hdr       (hdr),
      .o_frame     (frame),
      .o_frame_vld (frame_vld)
   );

   rffe_frame_seq #(.DATA_DEPTH(DATA_DEPTH)) u_frame_seq (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_tick      (tick),
      .i_frame     (frame),
      .i_frame_vld (frame_vld),
      .i_wr_byte   (wr_byte),
      .i_sdi       (i_sdi),
      .o_busy      (o_busy),
      .o_done      (o_done),
      .o_rd_idx    (rd_idx),
      .o_sclk_en   (sclk_en),
      .o_sdo       (o_sdo),
      .o_sdo_en    (o_sdo_en),
      .o_smp       (smp),
      .o_smp_bit   (smp_bit),
      .o_byte_end  (byte_end)
   );

   rffe_rd_capture u_rd_capture (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_frame_vld (frame_vld),
      .i_smp       (smp),
      .i_smp_bit   (smp_bit),
      .i_byte_end  (byte_end),
      .o_cap       (cap)
   );

   assign o_sclk = phase & sclk_en; // sclk idles low outside the frame and in ssc

endmodule

/* tb/rffe_checker.sv */
// bus monitor: detects the ssc, samples each bit at the sclk rise, compares with the reference
module rffe_checker (
   input  logic         clk,
   input  logic         i_rst_n,
   input  logic         i_sclk,
   input  logic         i_sdo,
   input  logic         i_sdo_en,
   input  logic         i_busy,
   input  logic         i_done,
   input  logic [8:0]   i_exp_len,
   input  logic [255:0] i_exp_en,
   input  logic [255:0] i_exp_sdo,
   output logic [15:0]  o_errors,
   output logic [15:0]  o_frames,
   output logic [15:0]  o_period   // clk cycles between the last two sclk rises
);

   logic        sclk_q;
   logic        en_q;
   logic        busy_q;
   logic        in_frame;
   logic        ssc_lo;     // low half of the ssc seen
   logic [8:0]  idx;        // bit number after the ssc
   logic [15:0] clk_cnt;
   logic [15:0] last_rise;
   logic        sclk_rise;
   logic        frame_open;

   assign sclk_rise  = i_sclk && !sclk_q;
   assign frame_open = !in_frame && i_sdo_en && !en_q && !i_sclk; // ssc drives sdo with sclk low

   always @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sclk_q    <= 1'b0;
         en_q      <= 1'b0;
         busy_q    <= 1'b0;
         in_frame  <= 1'b0;
         ssc_lo    <= 1'b0;
         idx       <= '0;
         clk_cnt   <= '0;
         last_rise <= '0;
         o_errors  <= '0;
         o_frames  <= '0;
         o_period  <= '0;
      end else begin
         sclk_q  <= i_sclk;
         en_q    <= i_sdo_en;
         busy_q  <= i_busy;
         clk_cnt <= clk_cnt + 1'b1;

         ////////////////////////////////////////////////////////////
         // sequence start, high then low
         ////////////////////////////////////////////////////////////
         if (frame_open) begin
            in_frame <= 1'b1;
            ssc_lo   <= 1'b0;
            if (i_sdo !== 1'b1) begin
               $display("mismatch: o_sdo in ssc expected 1 got %h", i_sdo);
               o_errors <= o_errors + 1'b1;
            end
         end
         if (in_frame && idx == '0 && !i_sclk && i_sdo_en && !i_sdo)
            ssc_lo <= 1'b1;

         ////////////////////////////////////////////////////////////
         // one bit per sclk rise
         ////////////////////////////////////////////////////////////
         if (sclk_rise) begin
            o_period  <= clk_cnt - last_rise;
            last_rise <= clk_cnt;
            idx       <= idx + 1'b1;
            if (idx >= i_exp_len) begin
               $display("error: sclk edge %0d beyond a frame of %0d bits", idx, i_exp_len);
               o_errors <= o_errors + 1'b1;
            end else if (idx == '0 && !ssc_lo) begin
               $display("error: no ssc low period before the first sclk edge");
               o_errors <= o_errors + 1'b1;
            end else if (i_sdo_en !== i_exp_en[idx]) begin
               $display("mismatch: o_sdo_en bit %0d expected %h got %h",
                        idx, i_exp_en[idx], i_sdo_en);
               o_errors <= o_errors + 1'b1;
            end else if (i_sdo_en && i_sdo !== i_exp_sdo[idx]) begin
               $display("mismatch: o_sdo bit %0d expected %h got %h",
                        idx, i_exp_sdo[idx], i_sdo);
               o_errors <= o_errors + 1'b1;
            end
         end

         // busy ends on the done edge and nowhere else
         if (i_done && i_busy !== 1'b0) begin
            $display("mismatch: o_busy with o_done expected 0 got %h", i_busy);
            o_errors <= o_errors + 1'b1;
         end
         if (i_done && busy_q !== 1'b1) begin
            $display("error: o_done came without a busy period before it");
            o_errors <= o_errors + 1'b1;
         end
         if (busy_q && !i_busy && !i_done) begin
            $display("error: o_busy fell without an o_done pulse");
            o_errors <= o_errors + 1'b1;
         end

         if (i_done) begin // frame closes, length must be complete
            if (idx != i_exp_len) begin
               $display("error: frame closed after %0d bits, expected %0d", idx, i_exp_len);
               o_errors <= o_errors + 1'b1;
            end
            o_frames <= o_frames + 1'b1;
            in_frame <= 1'b0;
            ssc_lo   <= 1'b0;
            idx      <= '0;
         end
      end
   end

endmodule

/* tb/tb_rffe_master.sv */
// testbench top: clock, reset, frame stimulus, read slave model, frame reference, test sequence
module tb_rffe_master;

   localparam int TIMEOUT = 20000; // clk cycles allowed per wait

   typedef struct packed {
      logic [8:0]   len;
      logic [255:0] en;
      logic [255:0] sdo;
   } exp_frame_t;

   logic         clk;
   logic         i_rst_n;
   logic         i_div_set;
   logic [7:0]   i_div;
   logic         i_start;
   logic         i_buf_wr;
   logic [4:0]   i_buf_addr;
   logic [7:0]   i_buf_wdata;
   logic         i_sdi = 1'b0;
   logic         o_busy;
   logic         o_done;
   logic [7:0]   o_buf_rdata;
   logic         o_sclk;
   logic         o_sdo;
   logic         o_sdo_en;
   logic [15:0]  chk_errors;
   logic [15:0]  chk_frames;
   logic [15:0]  chk_period;

   logic [31:0]  lfsr_q;
   exp_frame_t   exp_q;
   logic [3:0]   cur_sa;
   logic [7:0]   cur_cmd;
   logic [7:0]   cur_addr;
   logic [127:0] cur_data;        // data byte k at [8k +: 8]
   logic [7:0]   slv_bytes [16];
   int           slv_first;       // sclk rise of the first read data bit, -1 for none
   int           slv_n;
   int           slv_k = 0;
   logic         sclk_q;
   int           tb_errors;
   int           err_mark;
   int           tests_run;
   int           tests_failed;
   int           div_list [4] = '{0, 1, 5, 9};
   logic [7:0]   r;
   int           i;
   int           d;

   rffe_master #(.DIV_W(8), .DATA_DEPTH(16)) DUT (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_div_set   (i_div_set),
      .i_div       (i_div),
      .i_start     (i_start),
      .o_busy      (o_busy),
      .o_done      (o_done),
      .i_buf_wr    (i_buf_wr),
      .i_buf_addr  (i_buf_addr),
      .i_buf_wdata (i_buf_wdata),
      .o_buf_rdata (o_buf_rdata),
      .o_sclk      (o_sclk),
      .i_sdi       (i_sdi),
      .o_sdo       (o_sdo),
      .o_sdo_en    (o_sdo_en)
   );

   rffe_checker u_checker (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_sclk    (o_sclk),
      .i_sdo     (o_sdo),
      .i_sdo_en  (o_sdo_en),
      .i_busy    (o_busy),
      .i_done    (o_done),
      .i_exp_len (exp_q.len),
      .i_exp_en  (exp_q.en),
      .i_exp_sdo (exp_q.sdo),
      .o_errors  (chk_errors),
      .o_frames  (chk_frames),
      .o_period  (chk_period)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // random source and frame reference
   ////////////////////////////////////////////////////////////
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // taps 32 22 2 1
   endfunction

   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      int         k;
      v = '0;
      for (k = 0; k < n; k++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[6:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic exp_frame_t put_bit(input exp_frame_t f, input logic en, input logic b);
      f.en[f.len]  = en;
      f.sdo[f.len] = b;
      f.len        = f.len + 1'b1;
      return f;
   endfunction

   // bits after the ssc, one per sclk pulse
   function automatic exp_frame_t frame_ref(input logic [3:0] sa, input logic [7:0] cmd,
                                            input logic [7:0] addr, input logic [127:0] data);
      exp_frame_t f;
      logic [7:0] fld;
      logic       rd;
      logic       ext;
      int         nbytes;
      int         k;
      int         j;
      f   = '0;
      rd  = (cmd[7:5] == 3'b011) || (cmd[7:4] == 4'b0010);
      ext = (cmd[7:4] == 4'b0000) || (cmd[7:4] == 4'b0010);
      if (!ext && cmd[7:6] != 2'b01)
         return f; // unsupported, no bus activity
      fld    = ext ? cmd : {cmd[7:5], addr[4:0]};
      nbytes = ext ? int'(cmd[3:0]) + 1 : 1;
      for (k = 3; k >= 0; k--)
         f = put_bit(f, 1'b1, sa[k]);
      for (k = 7; k >= 0; k--)
         f = put_bit(f, 1'b1, fld[k]);
      f = put_bit(f, 1'b1, ~^{sa, fld}); // odd parity over 12 bits
      if (ext) begin
         for (k = 7; k >= 0; k--)
            f = put_bit(f, 1'b1, addr[k]);
         f = put_bit(f, 1'b1, ~^addr);
      end
      if (rd)
         f = put_bit(f, 1'b0, 1'b0); // turnaround
      for (j = 0; j < nbytes; j++) begin
         for (k = 7; k >= 0; k--)
            f = put_bit(f, !rd, rd ? 1'b0 : data[8*j+k]);
         f = put_bit(f, !rd, rd ? 1'b0 : ~^data[8*j+:8]);
      end
      f = put_bit(f, 1'b0, 1'b0); // closing bus park
      return f;
   endfunction

   ////////////////////////////////////////////////////////////
   // read slave, drives sdi one clk after each sclk rise
   ////////////////////////////////////////////////////////////
   function automatic logic slave_bit(input int k);
      int j;
      j = k - slv_first;
      if (slv_first < 0 || j < 0 || j >= 9 * slv_n)
         return 1'b0;
      if (j % 9 == 8)
         return ~^slv_bytes[j / 9];
      return slv_bytes[j / 9][7 - j % 9];
   endfunction

   always @(posedge clk) begin
      sclk_q <= o_sclk;
      if (i_start)
         slv_k <= 0;
      else if (o_sclk && !sclk_q) begin
         slv_k <= slv_k + 1;
         i_sdi <= slave_bit(slv_k);
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus tasks
   ////////////////////////////////////////////////////////////
   task automatic buf_write(input logic [4:0] a, input logic [7:0] v);
      @(posedge clk);
      i_buf_wr    <= 1'b1;
      i_buf_addr  <= a;
      i_buf_wdata <= v;
      @(posedge clk);
      i_buf_wr    <= 1'b0;
   endtask

   task automatic check_buf(input logic [4:0] a, input logic [7:0] v);
      @(posedge clk);
      i_buf_addr <= a;
      repeat (2) @(posedge clk); // one clk of read latency
      if (o_buf_rdata !== v) begin
         $display("mismatch: o_buf_rdata at address %0d expected %h got %h", a, v, o_buf_rdata);
         tb_errors++;
      end
   endtask

   task automatic wait_flag(input logic want_done, input string what);
      int n;
      for (n = 0; n < TIMEOUT; n++) begin
         @(posedge clk);
         if (want_done ? o_done : o_busy)
            return;
      end
      $display("timeout: %s never came", what);
      $display("TEST FAILED");
      $finish;
   endtask

   task automatic set_div(input int v);
      @(posedge clk);
      i_div_set <= 1'b1;
      i_div     <= 8'(v);
      @(posedge clk);
      i_div_set <= 1'b0;
   endtask

   task automatic random_body();
      int k;
      r        = rand_bits(4);
      cur_sa   = r[3:0];
      cur_addr = rand_bits(8);
      for (k = 0; k < 16; k++) begin
         cur_data[8*k+:8] = rand_bits(8);
         slv_bytes[k]     = rand_bits(8);
      end
   endtask

   task automatic prep_frame();
      int k;
      buf_write(5'd0, {4'h0, cur_sa});
      buf_write(5'd1, cur_cmd);
      buf_write(5'd2, cur_addr);
      for (k = 0; k < 16; k++)
         buf_write(5'(3 + k), cur_data[8*k+:8]);
      exp_q <= frame_ref(cur_sa, cur_cmd, cur_addr, cur_data);
      // read data follows sa, cmd, parity, the address byte if any, and the park bit
      slv_first = (cur_cmd[7:4] == 4'b0010) ? 23 : (cur_cmd[7:5] == 3'b011) ? 14 : -1;
      slv_n     = (cur_cmd[7:4] == 4'b0010) ? int'(cur_cmd[3:0]) + 1 : 1;
   endtask

   task automatic drive_start();
      @(posedge clk);
      i_start <= 1'b1;
      @(posedge clk);
      i_start <= 1'b0;
   endtask

   task automatic finish_frame();
      wait_flag(1'b1, "o_done");
      repeat (2) @(posedge clk); // checker counts settle
   endtask

   task automatic run_frame();
      prep_frame();
      drive_start();
      finish_frame();
   endtask

   task automatic start_test();
      err_mark = tb_errors + int'(chk_errors);
   endtask

   task automatic end_test(input string name);
      int now_err;
      now_err = tb_errors + int'(chk_errors);
      tests_run++;
      if (now_err != err_mark) begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name, now_err - err_mark);
      end else begin
         $display("test %0d %s: passed", tests_run, name);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      i_rst_n      = 1'b0;
      i_div_set    = 1'b0;
      i_div        = '0;
      i_start      = 1'b0;
      i_buf_wr     = 1'b0;
      i_buf_addr   = '0;
      i_buf_wdata  = '0;
      lfsr_q       = 32'h53a3;
      exp_q        = '0;
      slv_first    = -1;
      slv_n        = 0;
      tb_errors    = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (16) @(posedge clk);
      i_rst_n <= 1'b1;

      start_test();
      random_body();
      r       = rand_bits(5);
      cur_cmd = {3'b010, r[4:0]};
      run_frame();
      end_test("register write");

      start_test();
      random_body();
      r       = rand_bits(5);
      cur_cmd = {3'b011, r[4:0]};
      run_frame();
      check_buf(5'd3, slv_bytes[0]);
      end_test("register read");

      start_test();
      random_body();
      r       = rand_bits(4);
      cur_cmd = {4'b0000, r[3:0]};
      run_frame();
      end_test("extended write");

      start_test();
      random_body();
      r       = rand_bits(4);
      cur_cmd = {4'b0010, r[3:0]};
      run_frame();
      for (i = 0; i <= int'(r[3:0]); i++)
         check_buf(5'(3 + i), slv_bytes[i]);
      end_test("extended read");

      start_test();
      for (i = 0; i < 4; i++) begin
         set_div(div_list[i]);
         random_body();
         r       = rand_bits(5);
         cur_cmd = {3'b010, r[4:0]};
         run_frame();
         d = (div_list[i] < 2) ? 2 : div_list[i]; // smallest divider is 2
         if (int'(chk_period) != d) begin
            $display("mismatch: o_sclk period for div %0d expected %h got %h",
                     div_list[i], d, chk_period);
            tb_errors++;
         end
      end
      end_test("divider");

      start_test();
      random_body();
      r       = rand_bits(7);
      cur_cmd = {1'b1, r[6:0]}; // no supported form starts with 1
      run_frame();
      random_body();
      r       = rand_bits(5);
      cur_cmd = {3'b010, r[4:0]};
      prep_frame();
      drive_start();
      wait_flag(1'b0, "o_busy");
      buf_write(5'd3, ~cur_data[7:0]); // both must be dropped
      buf_write(5'd1, ~cur_cmd);
      finish_frame();
      check_buf(5'd3, cur_data[7:0]);
      check_buf(5'd1, cur_cmd);
      end_test("invalid command and busy writes");

      $display("summary: %0d tests, %0d failed, %0d errors, %0d frames seen by the checker",
               tests_run, tests_failed, tb_errors + int'(chk_errors), chk_frames);
      if (tests_failed == 0 && tb_errors + int'(chk_errors) == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* rffe_master.f */
common/rffe_pkg.sv
design/rffe_clk_div.sv
design/rffe_frame_buf.sv
rffe_engine/rffe_cmd_decode.sv
rffe_engine/rffe_frame_seq.sv
rffe_engine/rffe_rd_capture.sv
design/rffe_master.sv
tb/rffe_checker.sv
tb/tb_rffe_master.sv

/* Bender.yml */
package:
  name: rffe_master

sources:
  # shared package first
  - common/rffe_pkg.sv
  # rtl
  - design/rffe_clk_div.sv
  - design/rffe_frame_buf.sv
  - rffe_engine/rffe_cmd_decode.sv
  - rffe_engine/rffe_frame_seq.sv
  - rffe_engine/rffe_rd_capture.sv
  - design/rffe_master.sv
  # testbench
  - target: test
    files:
      - tb/rffe_checker.sv
      - tb/tb_rffe_master.sv
